// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = cam_frame_tb
FILELIST = filelist.f
OBJ_DIR  = obj_dir

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== filelist.f ====
source/cam_pkg.sv
source/apb_pkg.sv
source/ov7670_capture.sv
source/color_detector.sv
source/frame_mem_arbiter.sv
source/frame_buffer.sv
source/apb_regs.sv
source/cam_frame_top.sv
tb/cam_frame_chk.sv
tb/cam_frame_tb.sv

// ==== source/apb_pkg.sv ====
package apb_pkg;

    // bridge to slave
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [15:0] paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    // slave to bridge
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // register offsets
    typedef enum logic [15:0] {
        CTRL       = 16'h0000,
        THRESH     = 16'h0004,
        FRAME_CNT  = 16'h0008,
        TARGET_CNT = 16'h000C
    } reg_addr_e;

    // pixel n sits at PIX_BASE + 4n
    localparam logic [15:0] PIX_BASE = 16'h1000;

    // red min 16, green max 16, blue max 16
    localparam logic [31:0] THRESH_RST = 32'h0010_1010;

endpackage

// ==== source/apb_regs.sv ====
`timescale 1ns/10ps

module apb_regs (
    input  logic                       clk,
    input  logic                       i_rst_n,
    input  apb_pkg::apb_req_t          i_apb,
    input  logic [31:0]                i_frame_cnt,
    input  logic [15:0]                i_target_cnt,
    input  logic                       i_rd_valid,
    input  cam_pkg::pixel_t            i_rd_data,
    output apb_pkg::apb_rsp_t          o_apb,
    output logic                       o_enable,
    output cam_pkg::color_thresh_t     o_thresh,
    output logic                       o_rd_req,
    output logic [cam_pkg::ADDR_W-1:0] o_rd_addr
);

    typedef enum logic {
        IDLE,
        WAIT
    } rd_state_e;

    rd_state_e              state;
    logic                   access;
    logic                   in_win;
    logic [15:0]            win_off;
    logic                   ctrl_en;
    cam_pkg::color_thresh_t thresh;

    function automatic cam_pkg::color_thresh_t thresh_from_word(input logic [31:0] w);
        cam_pkg::color_thresh_t t;
        t.red_min   = w[4:0];
        t.green_max = w[13:8];
        t.blue_max  = w[20:16];
        return t;
    endfunction

    assign access  = i_apb.psel & i_apb.penable;
    assign win_off = i_apb.paddr - apb_pkg::PIX_BASE;

    // word aligned and inside the frame
    assign in_win = (i_apb.paddr >= apb_pkg::PIX_BASE)
                  && (int'(win_off[15:2]) < cam_pkg::FRAME_PIXELS)
                  && (win_off[1:0] == 2'b00);

    assign o_rd_addr = win_off[cam_pkg::ADDR_W+1:2];

    always_comb begin
        o_apb    = '0;
        o_rd_req = 1'b0;
        if (access) begin
            if (in_win) begin
                if (i_apb.pwrite) begin
                    o_apb.pready  = 1'b1;
                    o_apb.pslverr = 1'b1;
                end else if (state == WAIT) begin
                    o_apb.pready = i_rd_valid;
                    o_apb.prdata = {16'h0000, i_rd_data};
                end else begin
                    o_rd_req = 1'b1;
                end
            end else begin
                o_apb.pready = 1'b1;
                case (i_apb.paddr)
                    apb_pkg::CTRL: begin
                        o_apb.prdata = {31'b0, ctrl_en};
                    end
                    apb_pkg::THRESH: begin
                        o_apb.prdata = {11'b0, thresh.blue_max, 2'b0, thresh.green_max,
                                        3'b0, thresh.red_min};
                    end
                    apb_pkg::FRAME_CNT:  o_apb.prdata = i_frame_cnt;
                    apb_pkg::TARGET_CNT: o_apb.prdata = {16'h0000, i_target_cnt};
                    default:             o_apb.pslverr = 1'b1;
                endcase
            end
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ctrl_en <= 1'b0;
            thresh  <= thresh_from_word(apb_pkg::THRESH_RST);
        end else if (access && i_apb.pwrite && !in_win) begin
            // counters are read only, writes there are dropped
            case (i_apb.paddr)
                apb_pkg::CTRL:   ctrl_en <= i_apb.pwdata[0];
                apb_pkg::THRESH: thresh  <= thresh_from_word(i_apb.pwdata);
                default:         ;
            endcase
        end
    end

    // one outstanding pixel read
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (o_rd_req) state <= WAIT;
                WAIT:    if (i_rd_valid) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    assign o_enable = ctrl_en;
    assign o_thresh = thresh;

endmodule

// ==== source/cam_frame_top.sv ====
`timescale 1ns/10ps

module cam_frame_top (
    input  logic              clk,
    input  logic              i_rst_n,
    input  cam_pkg::cam_in_t  i_cam,
    input  apb_pkg::apb_req_t i_apb,
    output apb_pkg::apb_rsp_t o_apb
);

    cam_pkg::pix_wr_t           pix_wr;
    logic                       frame_done;
    logic                       cap_enable;
    cam_pkg::color_thresh_t     thresh;
    logic [31:0]                frame_cnt;
    logic [15:0]                target_cnt;
    logic                       rd_req;
    logic [cam_pkg::ADDR_W-1:0] rd_addr;
    logic                       rd_valid;
    cam_pkg::pixel_t            rd_data;
    logic                       mem_en;
    logic                       mem_we;
    logic [cam_pkg::ADDR_W-1:0] mem_addr;
    cam_pkg::pixel_t            mem_wdata;
    cam_pkg::pixel_t            mem_rdata;

    ov7670_capture u_capture (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_cam       (i_cam),
        .i_enable    (cap_enable),
        .o_pix_wr    (pix_wr),
        .o_frame_done(frame_done)
    );

    // watches the same write stream as the arbiter
    color_detector u_color_detector (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_pix_wr    (pix_wr),
        .i_frame_done(frame_done),
        .i_thresh    (thresh),
        .o_frame_cnt (frame_cnt),
        .o_target_cnt(target_cnt)
    );

    frame_mem_arbiter u_arbiter (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_pix_wr   (pix_wr),
        .i_rd_req   (rd_req),
        .i_rd_addr  (rd_addr),
        .i_mem_rdata(mem_rdata),
        .o_rd_valid (rd_valid),
        .o_rd_data  (rd_data),
        .o_mem_en   (mem_en),
        .o_mem_we   (mem_we),
        .o_mem_addr (mem_addr),
        .o_mem_wdata(mem_wdata)
    );

    frame_buffer u_frame_buffer (
        .clk    (clk),
        .i_en   (mem_en),
        .i_we   (mem_we),
        .i_addr (mem_addr),
        .i_wdata(mem_wdata),
        .o_rdata(mem_rdata)
    );

    apb_regs u_apb_regs (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_apb       (i_apb),
        .i_frame_cnt (frame_cnt),
        .i_target_cnt(target_cnt),
        .i_rd_valid  (rd_valid),
        .i_rd_data   (rd_data),
        .o_apb       (o_apb),
        .o_enable    (cap_enable),
        .o_thresh    (thresh),
        .o_rd_req    (rd_req),
        .o_rd_addr   (rd_addr)
    );

endmodule

// ==== source/cam_pkg.sv ====
package cam_pkg;

    // reduced frame so that simulation stays short
    localparam int FRAME_W      = 32;
    localparam int FRAME_H      = 24;
    localparam int FRAME_PIXELS = FRAME_W * FRAME_H;
    localparam int ADDR_W       = 10;

    // rgb565, high byte arrives first
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } pixel_t;

    // camera bus, already synchronous to clk
    typedef struct packed {
        logic       pclk_en;
        logic       vsync;
        logic       href;
        logic [7:0] data;
    } cam_in_t;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
        pixel_t            data;
    } pix_wr_t;

    // target colour window
    typedef struct packed {
        logic [4:0] red_min;
        logic [5:0] green_max;
        logic [4:0] blue_max;
    } color_thresh_t;

endpackage

// ==== source/color_detector.sv ====
`timescale 1ns/10ps

module color_detector (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  cam_pkg::pix_wr_t       i_pix_wr,
    input  logic                   i_frame_done,
    input  cam_pkg::color_thresh_t i_thresh,
    output logic [31:0]            o_frame_cnt,
    output logic [15:0]            o_target_cnt
);

    logic        hit;
    logic [15:0] run_cnt;

    // red at least the minimum, green and blue below their maximum
    assign hit = i_pix_wr.valid
               & (i_pix_wr.data.red >= i_thresh.red_min)
               & (i_pix_wr.data.green < i_thresh.green_max)
               & (i_pix_wr.data.blue < i_thresh.blue_max);

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            run_cnt      <= '0;
            o_target_cnt <= '0;
            o_frame_cnt  <= '0;
        end else if (i_frame_done) begin
            // a pixel landing with frame_done still belongs to this frame
            o_target_cnt <= run_cnt + 16'(hit);
            run_cnt      <= '0;
            o_frame_cnt  <= o_frame_cnt + 1'b1;
        end else if (hit) begin
            run_cnt <= run_cnt + 1'b1;
        end
    end

endmodule

// ==== source/frame_buffer.sv ====
`timescale 1ns/10ps

module frame_buffer (
    input  logic                       clk,
    input  logic                       i_en,
    input  logic                       i_we,
    input  logic [cam_pkg::ADDR_W-1:0] i_addr,
    input  cam_pkg::pixel_t            i_wdata,
    output cam_pkg::pixel_t            o_rdata
);

    cam_pkg::pixel_t mem [cam_pkg::FRAME_PIXELS];

    // read-first single port, maps onto one block ram
    always_ff @(posedge clk) begin
        if (i_en) begin
            if (i_we) begin
                mem[i_addr] <= i_wdata;
            end
            o_rdata <= mem[i_addr];
        end
    end

endmodule

// ==== source/frame_mem_arbiter.sv ====
`timescale 1ns/10ps

module frame_mem_arbiter (
    input  logic                       clk,
    input  logic                       i_rst_n,
    input  cam_pkg::pix_wr_t           i_pix_wr,
    input  logic                       i_rd_req,
    input  logic [cam_pkg::ADDR_W-1:0] i_rd_addr,
    input  cam_pkg::pixel_t            i_mem_rdata,
    output logic                       o_rd_valid,
    output cam_pkg::pixel_t            o_rd_data,
    output logic                       o_mem_en,
    output logic                       o_mem_we,
    output logic [cam_pkg::ADDR_W-1:0] o_mem_addr,
    output cam_pkg::pixel_t            o_mem_wdata
);

    logic                       rd_pend;
    logic [cam_pkg::ADDR_W-1:0] pend_addr;
    logic                       rd_want;
    logic                       rd_grant;
    logic [cam_pkg::ADDR_W-1:0] rd_addr_sel;

    assign rd_want     = i_rd_req | rd_pend;
    assign rd_addr_sel = rd_pend ? pend_addr : i_rd_addr;

    // writes always win, the capture side cannot stall
    assign rd_grant = rd_want & ~i_pix_wr.valid;

    assign o_mem_en    = i_pix_wr.valid | rd_grant;
    assign o_mem_we    = i_pix_wr.valid;
    assign o_mem_addr  = i_pix_wr.valid ? i_pix_wr.addr : rd_addr_sel;
    assign o_mem_wdata = i_pix_wr.data;

    // ram output is registered, so data lines up with rd_valid
    assign o_rd_data = i_mem_rdata;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rd_pend    <= 1'b0;
            o_rd_valid <= 1'b0;
        end else begin
            rd_pend    <= rd_want & i_pix_wr.valid;
            o_rd_valid <= rd_grant;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rd_req) begin
            pend_addr <= i_rd_addr;
        end
    end

endmodule

// ==== source/ov7670_capture.sv ====
`timescale 1ns/10ps

module ov7670_capture (
    input  logic             clk,
    input  logic             i_rst_n,
    input  cam_pkg::cam_in_t i_cam,
    input  logic             i_enable,
    output cam_pkg::pix_wr_t o_pix_wr,
    output logic             o_frame_done
);

    typedef enum logic [1:0] {
        IDLE,
        ACTIVE,
        SKIP
    } cap_state_e;

    cap_state_e                 state;
    logic                       vsync_q;
    logic                       vsync_fall;
    logic                       vsync_rise;
    logic                       take_byte;
    logic                       byte_phase;
    logic                       wrote_any;
    logic [7:0]                 hi_byte;
    logic [cam_pkg::ADDR_W-1:0] addr_cnt;
    logic                       wr_valid;
    logic [cam_pkg::ADDR_W-1:0] wr_addr;
    cam_pkg::pixel_t            wr_data;

    // vsync is only meaningful on pixel-clock cycles
    assign vsync_fall = i_cam.pclk_en & vsync_q & ~i_cam.vsync;
    assign vsync_rise = i_cam.pclk_en & ~vsync_q & i_cam.vsync;
    assign take_byte  = (state == ACTIVE) & i_cam.pclk_en & i_cam.href & ~i_cam.vsync;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state        <= IDLE;
            vsync_q      <= 1'b0;
            byte_phase   <= 1'b0;
            wrote_any    <= 1'b0;
            addr_cnt     <= '0;
            wr_valid     <= 1'b0;
            o_frame_done <= 1'b0;
        end else begin
            wr_valid     <= 1'b0;
            o_frame_done <= 1'b0;
            if (i_cam.pclk_en) begin
                vsync_q <= i_cam.vsync;
            end
            case (state)
                IDLE: begin
                    // acceptance is decided at the falling edge only
                    if (vsync_fall) begin
                        state      <= i_enable ? ACTIVE : SKIP;
                        addr_cnt   <= '0;
                        byte_phase <= 1'b0;
                        wrote_any  <= 1'b0;
                    end
                end
                ACTIVE: begin
                    if (vsync_rise) begin
                        state        <= IDLE;
                        o_frame_done <= wrote_any;
                    end else if (take_byte) begin
                        byte_phase <= ~byte_phase;
                        if (byte_phase) begin
                            wr_valid  <= 1'b1;
                            wrote_any <= 1'b1;
                            if (int'(addr_cnt) == cam_pkg::FRAME_PIXELS - 1) begin
                                addr_cnt <= '0;
                            end else begin
                                addr_cnt <= addr_cnt + 1'b1;
                            end
                        end
                    end
                end
                SKIP: begin
                    if (vsync_rise) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // byte pairing
    always_ff @(posedge clk) begin
        if (take_byte && !byte_phase) begin
            hi_byte <= i_cam.data;
        end
        if (take_byte && byte_phase) begin
            wr_addr <= addr_cnt;
            wr_data <= cam_pkg::pixel_t'({hi_byte, i_cam.data});
        end
    end

    assign o_pix_wr.valid = wr_valid;
    assign o_pix_wr.addr  = wr_addr;
    assign o_pix_wr.data  = wr_data;

endmodule

// ==== tb/cam_frame_chk.sv ====
`timescale 1ns/10ps

module cam_frame_chk (
    input logic                       clk,
    input logic                       i_rst_n,
    input logic                       i_wr_valid,
    input logic [cam_pkg::ADDR_W-1:0] i_wr_addr,
    input logic                       i_rd_grant,
    input logic                       i_rd_valid,
    input logic                       i_mem_en,
    input logic                       i_mem_we,
    input logic [cam_pkg::ADDR_W-1:0] i_mem_addr
);

    // writes never wait
    a_wr_granted: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_wr_valid |-> (i_mem_en && i_mem_we && (i_mem_addr == i_wr_addr)))
        else $error("write request not granted in its own cycle");

    a_rd_valid_next: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_rd_grant |=> i_rd_valid)
        else $error("read grant not followed by read valid");

    a_rd_valid_src: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_rd_valid |-> $past(i_rd_grant))
        else $error("read valid without a grant one cycle earlier");

    a_we_with_en: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_mem_we |-> i_mem_en)
        else $error("memory write enable without memory enable");

endmodule

bind frame_mem_arbiter cam_frame_chk u_chk (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_wr_valid(i_pix_wr.valid),
    .i_wr_addr (i_pix_wr.addr),
    .i_rd_grant(rd_grant),
    .i_rd_valid(o_rd_valid),
    .i_mem_en  (o_mem_en),
    .i_mem_we  (o_mem_we),
    .i_mem_addr(o_mem_addr)
);

// ==== tb/cam_frame_tb.sv ====
`timescale 1ns/10ps

module cam_frame_tb;

    localparam int NUM_FRAMES     = 4;
    localparam int NUM_READS      = 12;
    localparam int TIMEOUT_CYCLES =
        NUM_FRAMES * (4 * 2 * cam_pkg::FRAME_PIXELS + NUM_READS * 8) + 1000;
    localparam logic [31:0] THRESH_MASK = 32'h001F_3F1F;

    logic                   clk;
    logic                   i_rst_n;
    cam_pkg::cam_in_t       cam;
    apb_pkg::apb_req_t      apb_req;
    apb_pkg::apb_rsp_t      apb_rsp;

    logic [31:0]            rng_state;
    int                     cycles = 0;
    int                     pix_sent;
    cam_pkg::pixel_t        model_mem [cam_pkg::FRAME_PIXELS];
    logic [31:0]            model_frames;
    logic [15:0]            model_targets;
    cam_pkg::color_thresh_t model_thresh;
    logic                   model_enable;

    cam_frame_top u_dut (
        .clk    (clk),
        .i_rst_n(i_rst_n),
        .i_cam  (cam),
        .i_apb  (apb_req),
        .o_apb  (apb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            stop_with_failure($sformatf("run timed out after %0d cycles", cycles));
        end
    end

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // target rule: red at or above min, green and blue below max
    function automatic logic is_target(input cam_pkg::pixel_t p,
                                       input cam_pkg::color_thresh_t t);
        return (p.red >= t.red_min) && (p.green < t.green_max) && (p.blue < t.blue_max);
    endfunction

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_pixel(input string name, input cam_pkg::pixel_t exp,
                               input cam_pkg::pixel_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf("Error: %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp) begin
            stop_with_failure($sformatf("Error: %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_resp(input string name, input logic exp_err,
                              input apb_pkg::apb_rsp_t rsp);
        if (rsp.pslverr !== exp_err) begin
            stop_with_failure($sformatf("Error: %s pslverr expected %h actual %h",
                                        name, exp_err, rsp.pslverr));
        end
    endtask

    task automatic drive_cam(input logic pclk_en, input logic vsync, input logic href,
                             input logic [7:0] data);
        @(posedge clk);
        #2;
        cam.pclk_en = pclk_en;
        cam.vsync   = vsync;
        cam.href    = href;
        cam.data    = data;
    endtask

    // setup, access, then hold until pready
    task automatic apb_xfer(input logic write, input logic [15:0] addr,
                            input logic [31:0] wdata, output apb_pkg::apb_rsp_t rsp);
        @(posedge clk);
        #2;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk);
        #2;
        apb_req.penable = 1'b1;
        @(negedge clk);
        while (!apb_rsp.pready) begin
            @(negedge clk);
        end
        rsp = apb_rsp;
        @(posedge clk);
        #2;
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic reg_write(input logic [15:0] addr, input logic [31:0] data);
        apb_pkg::apb_rsp_t rsp;
        apb_xfer(1'b1, addr, data, rsp);
        check_resp($sformatf("write %h", addr), 1'b0, rsp);
    endtask

    task automatic reg_read(input logic [15:0] addr, output logic [31:0] data);
        apb_pkg::apb_rsp_t rsp;
        apb_xfer(1'b0, addr, 32'h0, rsp);
        check_resp($sformatf("read %h", addr), 1'b0, rsp);
        data = rsp.prdata;
    endtask

    task automatic read_pixel_check(input int idx);
        logic [31:0] data;
        reg_read(apb_pkg::PIX_BASE + 16'(idx * 4), data);
        check_pixel($sformatf("pixel[%0d]", idx), model_mem[idx], data[15:0]);
        check_word("prdata upper half", 32'h0, {16'h0, data[31:16]});
    endtask

    task automatic send_frame();
        logic [31:0] r;
        logic [15:0] word;
        logic [15:0] hits;
        hits = '0;
        drive_cam(1'b1, 1'b1, 1'b0, 8'h00);
        drive_cam(1'b1, 1'b1, 1'b0, 8'h00);
        // falling vsync opens the frame
        drive_cam(1'b1, 1'b0, 1'b0, 8'h00);
        for (int n = 0; n < cam_pkg::FRAME_PIXELS; n++) begin
            r    = lcg_next();
            word = r[31:16];
            for (int ph = 0; ph < 2; ph++) begin
                r = lcg_next();
                while (r[31:30] == 2'b00) begin
                    drive_cam(1'b0, 1'b0, 1'b1, r[23:16]);
                    r = lcg_next();
                end
                drive_cam(1'b1, 1'b0, 1'b1, (ph == 0) ? word[15:8] : word[7:0]);
            end
            if (model_enable) begin
                model_mem[n] = cam_pkg::pixel_t'(word);
                if (is_target(cam_pkg::pixel_t'(word), model_thresh)) begin
                    hits = hits + 16'd1;
                end
            end
            pix_sent = n + 1;
        end
        drive_cam(1'b1, 1'b0, 1'b0, 8'h00);
        drive_cam(1'b1, 1'b1, 1'b0, 8'h00);
        drive_cam(1'b0, 1'b1, 1'b0, 8'h00);
        if (model_enable) begin
            model_frames  = model_frames + 32'd1;
            model_targets = hits;
        end
    endtask

    initial begin
        logic [31:0]       r;
        logic [31:0]       data;
        logic [31:0]       thresh_word;
        int                mid_idx;
        apb_pkg::apb_rsp_t rsp;
        rng_state     = 32'h9bad;
        i_rst_n       = 1'b0;
        cam           = '0;
        apb_req       = '0;
        pix_sent      = 0;
        model_frames  = '0;
        model_targets = '0;
        model_enable  = 1'b0;
        thresh_word   = apb_pkg::THRESH_RST;
        repeat (3) @(posedge clk);
        #2;
        i_rst_n = 1'b1;

        reg_read(apb_pkg::CTRL, data);
        check_word("CTRL", 32'h0, data);
        reg_read(apb_pkg::THRESH, data);
        check_word("THRESH", apb_pkg::THRESH_RST, data);
        reg_read(apb_pkg::FRAME_CNT, data);
        check_word("FRAME_CNT", 32'h0, data);
        reg_read(apb_pkg::TARGET_CNT, data);
        check_word("TARGET_CNT", 32'h0, data);

        repeat (4) begin
            r = lcg_next();
            reg_write(apb_pkg::CTRL, r);
            reg_read(apb_pkg::CTRL, data);
            check_word("CTRL", r & 32'h1, data);
            r = lcg_next();
            reg_write(apb_pkg::THRESH, r);
            reg_read(apb_pkg::THRESH, data);
            check_word("THRESH", r & THRESH_MASK, data);
        end

        // frame 2 runs with capture off
        for (int f = 0; f < NUM_FRAMES; f++) begin
            model_enable = (f != 2);
            r = lcg_next();
            reg_write(apb_pkg::THRESH, r);
            thresh_word            = r;
            model_thresh.red_min   = r[4:0];
            model_thresh.green_max = r[13:8];
            model_thresh.blue_max  = r[20:16];
            reg_write(apb_pkg::CTRL, {31'b0, model_enable});
            r        = lcg_next();
            mid_idx  = int'(r[31:16]) % 196;
            pix_sent = 0;
            fork
                send_frame();
                begin
                    wait (pix_sent >= 200);
                    read_pixel_check(mid_idx);
                end
            join
            reg_read(apb_pkg::FRAME_CNT, data);
            check_word("FRAME_CNT", model_frames, data);
            reg_read(apb_pkg::TARGET_CNT, data);
            check_word("TARGET_CNT", {16'h0, model_targets}, data);
            repeat (8) begin
                r = lcg_next();
                read_pixel_check(int'(r[31:16]) % cam_pkg::FRAME_PIXELS);
            end
        end

        r       = lcg_next();
        mid_idx = int'(r[31:16]) % cam_pkg::FRAME_PIXELS;
        apb_xfer(1'b1, apb_pkg::PIX_BASE + 16'(mid_idx * 4), lcg_next(), rsp);
        check_resp("pixel window write", 1'b1, rsp);
        read_pixel_check(mid_idx);
        apb_xfer(1'b0, 16'h0010, 32'h0, rsp);
        check_resp("unmapped read", 1'b1, rsp);
        apb_xfer(1'b1, 16'h0020, 32'hffff_ffff, rsp);
        check_resp("unmapped write", 1'b1, rsp);
        apb_xfer(1'b0, apb_pkg::PIX_BASE + 16'(cam_pkg::FRAME_PIXELS * 4), 32'h0, rsp);
        check_resp("read past frame", 1'b1, rsp);
        reg_read(apb_pkg::CTRL, data);
        check_word("CTRL", {31'b0, model_enable}, data);
        reg_read(apb_pkg::THRESH, data);
        check_word("THRESH", thresh_word & THRESH_MASK, data);
        reg_read(apb_pkg::FRAME_CNT, data);
        check_word("FRAME_CNT", model_frames, data);
        reg_read(apb_pkg::TARGET_CNT, data);
        check_word("TARGET_CNT", {16'h0, model_targets}, data);

        $display("Simulation passed");
        $finish;
    end

endmodule
